// ==== build.f ====
+incdir+verilog
verilog/periph_bus_pkg.sv
verilog/display_pkg.sv
verilog/periph_decode.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/led_scan.sv
verilog/periph_top.sv
verif/periph_properties.sv
verif/periph_tb.sv

// ==== Bender.yml ====
package:
  name: periph

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/periph_bus_pkg.sv
      - verilog/display_pkg.sv
      - verilog/periph_decode.sv
      - verilog/uart_tx.sv
      - verilog/uart_rx.sv
      - verilog/led_scan.sv
      - verilog/periph_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/periph_properties.sv
      - verif/periph_tb.sv

// ==== verif/periph_tb.sv ====
`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_tb
    import periph_bus_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int FRAME_CYCLES    = 10 * `PERIPH_CLKS_PER_BIT;
    // Four frames plus margin, just under 1 ms
    localparam int WATCHDOG_CYCLES = 4 * FRAME_CYCLES + 10_000;

    logic         clk = 1'b0;
    logic         rst_reg_n;
    logic [27:0]  addr;
    access_size_t write_n;
    access_size_t read_n;
    logic [31:0]  wdata;
    logic [31:0]  rdata;
    logic [3:0]   buttons;
    logic         uart_txd;
    logic         uart_rxd;
    logic         uart_rts;
    logic [7:0]   leds;
    logic [3:0]   lcol;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Serial loopback
    assign uart_rxd = uart_txd;

    periph_top DUT (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .addr      (addr),
        .write_n   (write_n),
        .read_n    (read_n),
        .wdata     (wdata),
        .rdata     (rdata),
        .buttons   (buttons),
        .uart_txd  (uart_txd),
        .uart_rxd  (uart_rxd),
        .uart_rts  (uart_rts),
        .leds      (leds),
        .lcol      (lcol)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
            else stop_with_failure($sformatf("Error %s: expected %08h, actual %08h",
                                             name, expected, actual));
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic bus_write(input logic [27:0] a, input access_size_t size,
                             input logic [31:0] d);
        addr    = a;
        write_n = size;
        wdata   = d;
        @(posedge clk);
        #1;
        write_n = SIZE_NONE;
    endtask

    // Read data is combinational, sampled mid-cycle
    task automatic bus_read(input logic [27:0] a, output logic [31:0] d);
        addr   = a;
        read_n = SIZE_WORD;
        @(negedge clk);
        d = rdata;
        @(posedge clk);
        #1;
        read_n = SIZE_NONE;
    endtask

    task automatic wait_status_bit(input int idx, input logic level, input string what);
        logic [31:0] status;
        int          polls;
        polls = 0;
        bus_read(`PERIPH_ADDR_UART_STATUS, status);
        while (status[idx] !== level && polls < 2 * FRAME_CYCLES) begin
            polls++;
            bus_read(`PERIPH_ADDR_UART_STATUS, status);
        end
        if (status[idx] !== level) begin
            stop_with_failure($sformatf("Timed out waiting for %s", what));
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $fatal(1, "Watchdog timeout");
    end

    // Bound assertions stop the run at their first failure
    initial begin
        wait (DUT.u_props.fail_count != 0);
        $display("A bound assertion failed");
        $display("TEST FAILED");
        $fatal(1, "Assertion failure");
    end

    initial begin
        logic [31:0] model;
        logic [31:0] data;
        logic [31:0] rd;
        logic [27:0] bad_addr;
        logic [7:0]  tx_byte;
        logic [3:0]  seen;

        void'($urandom(32'hc07dbff3));
        rst_reg_n = 1'b0;
        addr      = '0;
        write_n   = SIZE_NONE;
        read_n    = SIZE_NONE;
        wdata     = '0;
        buttons   = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_reg_n = 1'b1;
        @(posedge clk);
        #1;

        // Reset state
        bus_read(`PERIPH_ADDR_GPIO_OUT, rd);
        check_value("reset_gpio_out", 32'h0, rd);
        bus_read(`PERIPH_ADDR_UART_STATUS, rd);
        check_value("reset_status", 32'h0, rd);
        check_value("reset_txd", 32'h1, uart_txd);
        check_value("reset_rts", 32'h0, uart_rts);

        // GPIO writes of every size against the model
        model = '0;
        for (int i = 0; i < 16; i++) begin
            data = $urandom;
            case ($urandom_range(2, 0))
                0: begin
                    bus_write(`PERIPH_ADDR_GPIO_OUT, SIZE_BYTE, data);
                    model[7:0] = data[7:0];
                end
                1: begin
                    bus_write(`PERIPH_ADDR_GPIO_OUT, SIZE_HALF, data);
                    model[15:0] = data[15:0];
                end
                default: begin
                    bus_write(`PERIPH_ADDR_GPIO_OUT, SIZE_WORD, data);
                    model = data;
                end
            endcase
            bus_read(`PERIPH_ADDR_GPIO_OUT, rd);
            check_value("gpio_write", model, rd);
        end

        // Buttons and unmapped space
        for (int i = 0; i < 4; i++) begin
            buttons = $urandom;
            bus_read(`PERIPH_ADDR_GPIO_IN, rd);
            check_value("gpio_in", {28'h0, buttons}, rd);
        end
        do begin
            bad_addr = $urandom;
        end while (bad_addr == `PERIPH_ADDR_GPIO_OUT || bad_addr == `PERIPH_ADDR_GPIO_IN ||
                   bad_addr == `PERIPH_ADDR_UART_DATA ||
                   bad_addr == `PERIPH_ADDR_UART_STATUS);
        bus_read(bad_addr, rd);
        check_value("unmapped_read", 32'hffff_ffff, rd);

        // UART loopback, second write lands while busy
        tx_byte = $urandom;
        bus_write(`PERIPH_ADDR_UART_DATA, SIZE_BYTE, {24'h0, tx_byte});
        bus_read(`PERIPH_ADDR_UART_STATUS, rd);
        check_value("uart_busy", 32'h1, rd);
        bus_write(`PERIPH_ADDR_UART_DATA, SIZE_BYTE, {24'h0, ~tx_byte});
        wait_status_bit(1, 1'b1, "rx_valid");
        bus_read(`PERIPH_ADDR_UART_DATA, rd);
        check_value("uart_loopback", {24'h0, tx_byte}, rd);

        // Read clears valid and RTS
        bus_read(`PERIPH_ADDR_UART_STATUS, rd);
        check_value("rx_valid_clear", 32'h0, rd[1]);
        check_value("rts_clear", 32'h0, uart_rts);
        wait_status_bit(0, 1'b0, "tx_busy low");
        // A queued second byte would show up within one more frame
        repeat (FRAME_CYCLES) @(posedge clk);
        #1;
        bus_read(`PERIPH_ADDR_UART_STATUS, rd);
        check_value("single_byte", 32'h0, rd);

        // LED scan over four full column cycles
        data = $urandom;
        bus_write(`PERIPH_ADDR_GPIO_OUT, SIZE_WORD, data);
        seen = '0;
        for (int c = 0; c < 4 * 4 * `PERIPH_SCAN_DIV; c++) begin
            @(negedge clk);
            seen = seen | lcol;
        end
        check_value("scan_columns", 32'hf, seen);
        @(posedge clk);
        #1;

        if (DUT.u_props.fail_count != 0) begin
            $display("A bound assertion failed");
            $display("TEST FAILED");
            $fatal(1, "Assertion failure");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// ==== verif/periph_properties.sv ====
`timescale 1ns/1ps

module periph_properties
    import periph_bus_pkg::*;
    import display_pkg::*;
(
    input logic         clk,
    input logic         rst_reg_n,
    input logic         tx_start,
    input logic         tx_busy,
    input logic         uart_txd,
    input logic         rx_valid,
    input logic         uart_rts,
    input gpio_word_u   gpio_word,
    input logic [7:0]   leds,
    input logic [3:0]   lcol
);

    // Failed assertions so far, watched by the testbench
    int unsigned fail_count = 0;
    led_col_t    col;

    // Column number from the one-hot enable
    always_comb begin
        case (lcol)
            4'b0010: col = 2'd1;
            4'b0100: col = 2'd2;
            4'b1000: col = 2'd3;
            default: col = 2'd0;
        endcase
    end

    // Everything idle when reset lets go
    reset_idle: assert property (@(posedge clk)
        $rose(rst_reg_n) |-> (uart_txd && !tx_busy && !rx_valid && lcol == 4'b0001))
        else begin
            fail_count++;
            $error("UART or scanner not idle after reset");
        end

    // Line stays high between frames
    idle_line_high: assert property (@(posedge clk) disable iff (!rst_reg_n)
        !tx_busy |-> uart_txd)
        else begin
            fail_count++;
            $error("uart_txd low while the transmitter is idle");
        end

    lcol_onehot: assert property (@(posedge clk) disable iff (!rst_reg_n)
        $onehot(lcol))
        else begin
            fail_count++;
            $error("lcol is not one-hot");
        end

    // Digit 0 is the top byte of the word
    leds_show_digit: assert property (@(posedge clk) disable iff (!rst_reg_n)
        leds == gpio_word.word[8 * (3 - col) +: 8])
        else begin
            fail_count++;
            $error("leds do not match the digit of the active column");
        end

    rts_follows_valid: assert property (@(posedge clk) disable iff (!rst_reg_n)
        uart_rts == rx_valid)
        else begin
            fail_count++;
            $error("uart_rts differs from rx_valid");
        end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_reg_n)
        (tx_start && !tx_busy) |=> tx_busy)
        else begin
            fail_count++;
            $error("tx_busy did not rise after an accepted tx_start");
        end

endmodule

bind periph_top periph_properties u_props (
    .clk       (clk),
    .rst_reg_n (rst_reg_n),
    .tx_start  (tx_start),
    .tx_busy   (tx_busy),
    .uart_txd  (uart_txd),
    .rx_valid  (rx_valid),
    .uart_rts  (uart_rts),
    .gpio_word (gpio_word),
    .leds      (leds),
    .lcol      (lcol)
);

// ==== verilog/periph_top.sv ====
`timescale 1ns/1ps

module periph_top
    import periph_bus_pkg::*;
    import display_pkg::*;
(
    input  logic         clk,
    input  logic         rst_reg_n,
    input  logic [27:0]  addr,
    input  access_size_t write_n,
    input  access_size_t read_n,
    input  logic [31:0]  wdata,
    output logic [31:0]  rdata,
    input  logic [3:0]   buttons,
    output logic         uart_txd,
    input  logic         uart_rxd,
    output logic         uart_rts,
    output logic [7:0]   leds,
    output logic [3:0]   lcol
);

    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;
    logic       rx_read;
    logic       rx_valid;
    logic [7:0] rx_data;
    gpio_word_u gpio_word;

    // Address decode and registers on the data port
    periph_decode u_decode (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .addr      (addr),
        .write_n   (write_n),
        .read_n    (read_n),
        .wdata     (wdata),
        .rdata     (rdata),
        .buttons   (buttons),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .rx_read   (rx_read),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .gpio_word (gpio_word)
    );

    uart_tx u_uart_tx (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .uart_txd  (uart_txd),
        .tx_busy   (tx_busy)
    );

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .uart_rxd  (uart_rxd),
        .rx_read   (rx_read),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .uart_rts  (uart_rts)
    );

    // GPIO word shown on the LED matrix
    led_scan u_led_scan (
        .clk       (clk),
        .rst_reg_n (rst_reg_n),
        .gpio_word (gpio_word),
        .leds      (leds),
        .lcol      (lcol)
    );

endmodule

// ==== verilog/led_scan.sv ====
`timescale 1ns/1ps

`include "periph_defines.svh"

module led_scan
    import display_pkg::*;
(
    input  logic       clk,
    input  logic       rst_reg_n,
    input  gpio_word_u gpio_word,
    output logic [7:0] leds,
    output logic [3:0] lcol
);

    localparam int SCAN_DIV = `PERIPH_SCAN_DIV;
    localparam int DIV_W    = $clog2(SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;
    led_col_t         col;

    // Step to the next column every SCAN_DIV clocks
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            div_cnt <= '0;
            col     <= '0;
        end else if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
            div_cnt <= '0;
            col     <= col + 2'd1;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    // One-hot column enable
    always_comb begin
        lcol      = 4'b0000;
        lcol[col] = 1'b1;
    end

    // Digit byte for the active column, follows GPIO writes directly
    assign leds = gpio_word.digit[col];

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

`include "periph_defines.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst_reg_n,
    input  logic       uart_rxd,
    input  logic       rx_read,
    output logic       rx_valid,
    output logic [7:0] rx_data,
    output logic       uart_rts
);

    localparam int CLKS_PER_BIT = `PERIPH_CLKS_PER_BIT;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    logic             rx_meta;
    logic             rx_sync;
    logic             active;
    logic [CNT_W-1:0] clk_cnt;
    // 0 is the start bit, 9 the stop bit
    logic [3:0]       bit_idx;
    logic [7:0]       shift;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            active   <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            if (rx_read) begin
                rx_valid <= 1'b0;
            end

            if (!active) begin
                // Falling edge, aim the first sample at mid start bit
                if (!rx_sync) begin
                    active  <= 1'b1;
                    clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_idx <= '0;
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - CNT_W'(1);
            end else begin
                clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0) begin
                    // Glitch, not a real start bit
                    if (rx_sync) begin
                        active <= 1'b0;
                    end
                end else if (bit_idx == 4'd9) begin
                    active <= 1'b0;
                    // Byte is lost if the last one is still unread
                    if (rx_sync && !rx_valid) begin
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (active && clk_cnt == '0) begin
            if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
                shift <= {rx_sync, shift[7:1]};
            end else if (bit_idx == 4'd9 && rx_sync && !rx_valid) begin
                rx_data <= shift;
            end
        end
    end

    // Not ready while a byte waits
    assign uart_rts = rx_valid;

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

`include "periph_defines.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst_reg_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       uart_txd,
    output logic       tx_busy
);

    localparam int CLKS_PER_BIT = `PERIPH_CLKS_PER_BIT;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    // Stop, data LSB first, start; bit 0 is on the line
    logic [9:0]       shift;

    assign uart_txd = shift[0];

    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            shift   <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_busy <= 1'b0;
        end else if (!tx_busy) begin
            // Starts while busy are dropped
            if (tx_start) begin
                shift   <= {1'b1, tx_data, 1'b0};
                clk_cnt <= '0;
                bit_cnt <= '0;
                tx_busy <= 1'b1;
            end
        end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt <= '0;
            shift   <= {1'b1, shift[9:1]};
            // Busy ends with the stop bit
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt + CNT_W'(1);
        end
    end

endmodule

// ==== verilog/periph_decode.sv ====
`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_decode
    import periph_bus_pkg::*;
    import display_pkg::*;
(
    input  logic         clk,
    input  logic         rst_reg_n,
    input  logic [27:0]  addr,
    input  access_size_t write_n,
    input  access_size_t read_n,
    input  logic [31:0]  wdata,
    output logic [31:0]  rdata,
    input  logic [3:0]   buttons,
    output logic         tx_start,
    output logic [7:0]   tx_data,
    input  logic         tx_busy,
    output logic         rx_read,
    input  logic         rx_valid,
    input  logic [7:0]   rx_data,
    output gpio_word_u   gpio_word
);

    periph_sel_t sel;
    logic        wr_en;
    logic        rd_en;

    assign wr_en = (write_n != SIZE_NONE);
    assign rd_en = (read_n != SIZE_NONE);

    // Address to peripheral
    always_comb begin
        case (addr)
            `PERIPH_ADDR_GPIO_OUT:    sel = SEL_GPIO_OUT;
            `PERIPH_ADDR_GPIO_IN:     sel = SEL_GPIO_IN;
            `PERIPH_ADDR_UART_DATA:   sel = SEL_UART_DATA;
            `PERIPH_ADDR_UART_STATUS: sel = SEL_UART_STATUS;
            default:                  sel = SEL_NONE;
        endcase
    end

    // Read data, valid in the same cycle as addr
    always_comb begin
        case (sel)
            SEL_GPIO_OUT:    rdata = gpio_word.word;
            SEL_GPIO_IN:     rdata = {28'h0, buttons};
            SEL_UART_DATA:   rdata = {24'h0, rx_data};
            SEL_UART_STATUS: rdata = {30'h0, rx_valid, tx_busy};
            default:         rdata = 32'hffff_ffff;
        endcase
    end

    // GPIO output register, narrow writes touch the low bits only
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            gpio_word.word <= 32'h0;
        end else if (wr_en && sel == SEL_GPIO_OUT) begin
            case (write_n)
                SIZE_WORD: gpio_word.word <= wdata;
                SIZE_HALF: gpio_word.word[15:0] <= wdata[15:0];
                SIZE_BYTE: gpio_word.word[7:0] <= wdata[7:0];
                default:   gpio_word.word <= gpio_word.word;
            endcase
        end
    end

    // UART strobes, one cycle per access
    assign tx_start = wr_en && (sel == SEL_UART_DATA);
    assign tx_data  = wdata[7:0];
    assign rx_read  = rd_en && (sel == SEL_UART_DATA);

endmodule

// ==== verilog/display_pkg.sv ====
package display_pkg;

    // GPIO output word, also seen as four LED digit bytes
    // Digit 0 sits in the top byte
    typedef union packed {
        logic [31:0]      word;
        logic [0:3][7:0]  digit;
    } gpio_word_u;

    // Active LED column
    typedef logic [1:0] led_col_t;

endpackage

// ==== verilog/periph_bus_pkg.sv ====
package periph_bus_pkg;

    // Size code carried on write_n and read_n
    // All ones means no access this cycle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_t;

    // Peripheral picked by the address decoder
    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_GPIO_OUT,
        SEL_GPIO_IN,
        SEL_UART_DATA,
        SEL_UART_STATUS
    } periph_sel_t;

endpackage

// ==== verilog/periph_defines.svh ====
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// System clock rate in Hz
`define PERIPH_CLK_HZ 40_000_000

// UART line rate in bits per second
`define PERIPH_BIT_RATE 115_200

// Clocks per UART bit, 347 at the rates above
`define PERIPH_CLKS_PER_BIT (`PERIPH_CLK_HZ / `PERIPH_BIT_RATE)

// Clocks spent on each LED column
`define PERIPH_SCAN_DIV 64

// Peripheral addresses on the 28-bit data port
`define PERIPH_ADDR_GPIO_OUT 28'h800_0000
`define PERIPH_ADDR_GPIO_IN 28'h800_0004
`define PERIPH_ADDR_UART_DATA 28'h800_0010
`define PERIPH_ADDR_UART_STATUS 28'h800_0014

`endif
